// ==== Bender.yml ====
package:
  name: baseband_rx

export_include_dirs:
  - include

sources:
  - files:
      - design/baseband_pkg.sv
      - design/header_sync.sv
      - design/symbol_mapper.sv
      - design/baseband_rx_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/baseband_rx_tb.sv

// ==== design/baseband_pkg.sv ====
package baseband_pkg;

   // modulation opcode, the unused code 2'b11 is mapped as bpsk
   typedef enum logic [1:0] {
      MOD_BPSK  = 2'b00,
      MOD_QPSK  = 2'b01,
      MOD_QAM16 = 2'b10
   } mod_t;

   typedef enum logic {
      ST_HUNT    = 1'b0,
      ST_PAYLOAD = 1'b1
   } sync_state_t;

   // signed amplitude on one axis, -3 to +3
   typedef logic signed [2:0] sym_level_t;

   function automatic logic [2:0] bits_per_symbol(input mod_t m);
      case (m)
         MOD_QPSK:  return 3'd2;
         MOD_QAM16: return 3'd4;
         default:   return 3'd1;
      endcase
   endfunction

   // antipodal level for one bit
   function automatic sym_level_t bpsk_level(input logic b);
      if (b) begin
         return sym_level_t'(3);
      end
      return sym_level_t'(-3);
   endfunction

   // gray order 00 to -3, 01 to -1, 11 to +1, 10 to +3
   function automatic sym_level_t gray_level(input logic [1:0] b);
      case (b)
         2'b00:   return sym_level_t'(-3);
         2'b01:   return sym_level_t'(-1);
         2'b11:   return sym_level_t'(1);
         default: return sym_level_t'(3);
      endcase
   endfunction

endpackage

// ==== design/baseband_rx_top.sv ====
`timescale 1ns/100ps

module baseband_rx_top
   import baseband_pkg::*;
#(
   parameter logic [11:0] SYNC_WORD    = 12'b1011_0011_1000,
   parameter int unsigned PAYLOAD_BITS = 48
) (
   input  logic       data_clk,
   input  logic       rst_n,
   input  logic       enable,
   input  logic       data_in,
   input  mod_t       mod_sel,
   output logic       sym_valid,
   output sym_level_t sym_i,
   output sym_level_t sym_q,
   output logic       frame_active,
   output logic       frame_done
);

   // synchronizer to mapper
   logic payload_strobe;
   logic payload_bit;
   logic frame_start;
   logic frame_last;

   header_sync #(
      .SYNC_WORD    (SYNC_WORD),
      .PAYLOAD_BITS (PAYLOAD_BITS)
   ) sync_i (
      .data_clk       (data_clk),
      .rst_n          (rst_n),
      .enable         (enable),
      .data_in        (data_in),
      .payload_strobe (payload_strobe),
      .payload_bit    (payload_bit),
      .frame_start    (frame_start),
      .frame_last     (frame_last),
      .frame_active   (frame_active)
   );

   // symbols come out one clock after the payload strobe
   symbol_mapper mapper_i (
      .data_clk       (data_clk),
      .rst_n          (rst_n),
      .mod_sel        (mod_sel),
      .frame_start    (frame_start),
      .payload_strobe (payload_strobe),
      .payload_bit    (payload_bit),
      .frame_last     (frame_last),
      .sym_valid      (sym_valid),
      .sym_i          (sym_i),
      .sym_q          (sym_q),
      .frame_done     (frame_done)
   );

endmodule

// ==== design/header_sync.sv ====
`timescale 1ns/100ps

module header_sync
   import baseband_pkg::*;
#(
   parameter logic [11:0] SYNC_WORD    = 12'b1011_0011_1000,
   parameter int unsigned PAYLOAD_BITS = 48
) (
   input  logic data_clk,
   input  logic rst_n,
   input  logic enable,
   input  logic data_in,
   output logic payload_strobe,
   output logic payload_bit,
   output logic frame_start,
   output logic frame_last,
   output logic frame_active
);

   localparam int CNT_W = $clog2(PAYLOAD_BITS + 1);

   sync_state_t      state;
   logic [11:0]      shift_reg;
   logic [11:0]      shift_next;
   logic [CNT_W-1:0] bits_left;
   logic             sync_hit;
   logic             payload_take;
   logic             last_bit;

   // window with the bit on the input included
   assign shift_next   = {shift_reg[10:0], data_in};
   assign sync_hit     = enable && (state == ST_HUNT) && (shift_next == SYNC_WORD);
   assign payload_take = enable && (state == ST_PAYLOAD);
   assign last_bit     = payload_take && (bits_left == CNT_W'(1));

   always_ff @(posedge data_clk or negedge rst_n) begin
      if (!rst_n) begin
         shift_reg <= '0;
      end else if (last_bit) begin
         // payload history must not seed the next sync word
         shift_reg <= '0;
      end else if (enable) begin
         shift_reg <= shift_next;
      end
   end

   // hunt / payload FSM with the window down-counter
   always_ff @(posedge data_clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= ST_HUNT;
         bits_left <= '0;
      end else begin
         case (state)
            ST_HUNT: begin
               if (sync_hit) begin
                  state     <= ST_PAYLOAD;
                  bits_left <= CNT_W'(PAYLOAD_BITS);
               end
            end
            ST_PAYLOAD: begin
               if (payload_take) begin
                  bits_left <= bits_left - CNT_W'(1);
                  if (last_bit) begin
                     state <= ST_HUNT;
                  end
               end
            end
            default: begin
               state     <= ST_HUNT;
               bits_left <= '0;
            end
         endcase
      end
   end

   // strobes run one clock behind the enable that caused them
   always_ff @(posedge data_clk or negedge rst_n) begin
      if (!rst_n) begin
         payload_strobe <= 1'b0;
         frame_start    <= 1'b0;
         frame_last     <= 1'b0;
         frame_active   <= 1'b0;
      end else begin
         payload_strobe <= payload_take;
         frame_start    <= sync_hit;
         frame_last     <= last_bit;
         if (sync_hit) begin
            frame_active <= 1'b1;
         end else if (payload_strobe && frame_last) begin
            // stays up through the final strobe
            frame_active <= 1'b0;
         end
      end
   end

   always_ff @(posedge data_clk) begin
      if (payload_take) begin
         payload_bit <= data_in;
      end
   end

   // mapper groups are at most four bits, frames must end on a group boundary
   if (PAYLOAD_BITS % 4 != 0) begin : g_len_check
      $error("PAYLOAD_BITS (%0d) is not a multiple of 4", PAYLOAD_BITS);
   end

   a_strobe_in_frame : assert property (
      @(posedge data_clk) disable iff (!rst_n)
      $rose(payload_strobe) |-> frame_active
   ) else $error("payload strobe raised outside the payload window");

   // first payload strobe comes at least one clock after frame_start
   a_start_apart : assert property (
      @(posedge data_clk) disable iff (!rst_n)
      frame_start |-> !payload_strobe
   ) else $error("frame_start and payload_strobe in the same cycle");

endmodule

// ==== design/symbol_mapper.sv ====
`timescale 1ns/100ps

module symbol_mapper
   import baseband_pkg::*;
(
   input  logic       data_clk,
   input  logic       rst_n,
   input  mod_t       mod_sel,
   input  logic       frame_start,
   input  logic       payload_strobe,
   input  logic       payload_bit,
   input  logic       frame_last,
   output logic       sym_valid,
   output sym_level_t sym_i,
   output sym_level_t sym_q,
   output logic       frame_done
);

   mod_t       mod_q;
   logic [3:0] grp_q;
   logic [3:0] grp_next;
   logic [2:0] grp_cnt;
   logic       grp_full;
   sym_level_t map_i;
   sym_level_t map_q;

   // first bit of a group ends up highest
   assign grp_next = {grp_q[2:0], payload_bit};
   assign grp_full = payload_strobe && ((grp_cnt + 3'd1) == bits_per_symbol(mod_q));

   // modulation is frozen for the whole frame
   always_ff @(posedge data_clk or negedge rst_n) begin
      if (!rst_n) begin
         mod_q   <= MOD_BPSK;
         grp_cnt <= '0;
      end else if (frame_start) begin
         mod_q   <= mod_sel;
         grp_cnt <= '0;
      end else if (payload_strobe) begin
         if (grp_full) begin
            grp_cnt <= '0;
         end else begin
            grp_cnt <= grp_cnt + 3'd1;
         end
      end
   end

   always_ff @(posedge data_clk) begin
      if (payload_strobe) begin
         grp_q <= grp_next;
      end
   end

   // map the completed group, stale upper bits are ignored for bpsk and qpsk
   always_comb begin
      case (mod_q)
         MOD_QPSK: begin
            map_i = bpsk_level(grp_next[1]);
            map_q = bpsk_level(grp_next[0]);
         end
         MOD_QAM16: begin
            map_i = gray_level(grp_next[3:2]);
            map_q = gray_level(grp_next[1:0]);
         end
         default: begin
            map_i = bpsk_level(grp_next[0]);
            map_q = '0;
         end
      endcase
   end

   always_ff @(posedge data_clk or negedge rst_n) begin
      if (!rst_n) begin
         sym_valid  <= 1'b0;
         frame_done <= 1'b0;
      end else begin
         sym_valid  <= grp_full;
         frame_done <= grp_full && frame_last;
      end
   end

   always_ff @(posedge data_clk) begin
      if (grp_full) begin
         sym_i <= map_i;
         sym_q <= map_q;
      end
   end

   a_done_with_valid : assert property (
      @(posedge data_clk) disable iff (!rst_n)
      frame_done |-> sym_valid
   ) else $error("frame_done without sym_valid");

   // the synchronizer window has to close exactly on a symbol boundary
   a_last_closes_group : assert property (
      @(posedge data_clk) disable iff (!rst_n)
      (payload_strobe && frame_last) |=> (sym_valid && frame_done)
   ) else $error("last payload bit left a partial symbol group");

endmodule

// ==== include/rx_ref_model.svh ====
`ifndef RX_REF_MODEL_SVH
`define RX_REF_MODEL_SVH

// lcg state, one stream for payload, noise and gaps
int unsigned lcg_state = 32'd96269;

function automatic int unsigned lcg_next();
   lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
   // low bits of an lcg cycle quickly
   return lcg_state >> 8;
endfunction

function automatic logic lcg_bit();
   int unsigned v;
   v = lcg_next();
   return v[0];
endfunction

// expected {i, q} for one group, first bit highest and right aligned
function automatic logic [5:0] ref_map(input baseband_pkg::mod_t m, input logic [3:0] grp);
   baseband_pkg::sym_level_t i_lvl;
   baseband_pkg::sym_level_t q_lvl;
   i_lvl = grp[0] ? 3'sd3 : -3'sd3;
   q_lvl = '0;
   if (m == baseband_pkg::MOD_QPSK) begin
      i_lvl = grp[1] ? 3'sd3 : -3'sd3;
      q_lvl = grp[0] ? 3'sd3 : -3'sd3;
   end else if (m == baseband_pkg::MOD_QAM16) begin
      i_lvl = baseband_pkg::gray_level(grp[3:2]);
      q_lvl = baseband_pkg::gray_level(grp[1:0]);
   end
   return {i_lvl, q_lvl};
endfunction

task automatic random_payload(input int unsigned n, output logic payload[$]);
   payload = {};
   repeat (n) begin
      payload.push_back(lcg_bit());
   end
endtask

// sync word msb first, then the payload
task automatic build_frame(input logic [11:0] sync, input logic payload[$],
                           output logic bits[$]);
   bits = {};
   for (int k = 11; k >= 0; k--) begin
      bits.push_back(sync[k]);
   end
   foreach (payload[k]) begin
      bits.push_back(payload[k]);
   end
endtask

// random bits that never complete the sync word, starting from a cleared window
task automatic noise_bits(input logic [11:0] sync, input int unsigned n,
                          output logic bits[$]);
   logic [11:0] win;
   logic        b;
   win  = '0;
   bits = {};
   repeat (n) begin
      b = lcg_bit();
      if ({win[10:0], b} == sync) begin
         b = ~b;
      end
      win = {win[10:0], b};
      bits.push_back(b);
   end
endtask

task automatic expected_symbols(input baseband_pkg::mod_t m, input logic payload[$],
                                output logic [5:0] syms[$]);
   int unsigned bps;
   int unsigned cnt;
   logic [3:0]  grp;
   bps  = baseband_pkg::bits_per_symbol(m);
   cnt  = 0;
   grp  = '0;
   syms = {};
   foreach (payload[k]) begin
      grp = {grp[2:0], payload[k]};
      cnt++;
      if (cnt == bps) begin
         syms.push_back(ref_map(m, grp));
         cnt = 0;
      end
   end
endtask

`endif

// ==== sim/baseband_rx_tb.sv ====
`timescale 1ns/100ps

module baseband_rx_tb
   import baseband_pkg::*;
();

   localparam logic [11:0] SYNC_WORD    = 12'b1011_0011_1000;
   localparam int          PAYLOAD_BITS = 48;
   localparam int          MAX_GAP      = 3;
   // upper bound on bits driven over all tests
   localparam int          BITS_SENT    = 900;
   // at most MAX_GAP + 1 cycles per bit plus margin for drains and resets
   localparam int          TIMEOUT_CYCLES = BITS_SENT * (MAX_GAP + 1) + 1000;

   logic       data_clk;
   logic       rst_n;
   logic       enable;
   logic       data_in;
   mod_t       mod_sel;
   logic       sym_valid;
   sym_level_t sym_i;
   sym_level_t sym_q;
   logic       frame_active;
   logic       frame_done;

   // {last symbol of frame, i, q}
   logic [6:0] exp_q[$];
   int         check_errors = 0;
   int         other_errors = 0;
   int         sym_seen     = 0;
   int         cycle_cnt    = 0;
   logic       expect_idle  = 1'b0;

   `include "rx_ref_model.svh"

   baseband_rx_top dut_i (
      .data_clk     (data_clk),
      .rst_n        (rst_n),
      .enable       (enable),
      .data_in      (data_in),
      .mod_sel      (mod_sel),
      .sym_valid    (sym_valid),
      .sym_i        (sym_i),
      .sym_q        (sym_q),
      .frame_active (frame_active),
      .frame_done   (frame_done)
   );

   always #10 data_clk = ~data_clk;

   always @(posedge data_clk) begin
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("timeout, run still going after %0d cycles", cycle_cnt);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t: %s, got %0h expected %0h", $time, what, got, exp);
         check_errors++;
      end
   endtask

   // outputs settle between rising edges and are sampled on the falling edge
   always @(negedge data_clk) begin : compare
      logic [6:0] head;
      if (rst_n) begin
         if (expect_idle && (frame_active || sym_valid)) begin
            $display("payload window opened at %0t although no sync word was sent", $time);
            other_errors++;
         end
         if (sym_valid) begin
            sym_seen++;
            if (exp_q.size() == 0) begin
               $display("unexpected sym_valid at %0t with no symbol pending", $time);
               other_errors++;
            end else begin
               head = exp_q.pop_front();
               check_value({sym_i, sym_q}, head[5:0], "symbol i and q");
               check_value(frame_done, head[6], "frame_done");
               // window closes on the final strobe before the last symbol
               check_value(frame_active, !head[6], "frame_active with symbol");
            end
         end else if (frame_done) begin
            $display("frame_done pulsed at %0t without sym_valid", $time);
            other_errors++;
         end
      end
   end

   // one bit per enable with an optional random gap before each
   task automatic send_bits(input logic bits[$], input int max_gap);
      int gap;
      foreach (bits[k]) begin
         gap = (max_gap > 0) ? int'(lcg_next() % (max_gap + 1)) : 0;
         repeat (gap) begin
            @(negedge data_clk);
            enable = 1'b0;
         end
         @(negedge data_clk);
         enable  = 1'b1;
         data_in = bits[k];
      end
      @(negedge data_clk);
      enable = 1'b0;
   endtask

   // ones then zeros leave the window all zero without passing the sync word
   task automatic clear_window(input int max_gap);
      logic bits[$];
      bits = {};
      repeat (12) begin
         bits.push_back(1'b1);
      end
      repeat (12) begin
         bits.push_back(1'b0);
      end
      send_bits(bits, max_gap);
   endtask

   task automatic send_frame(input mod_t m, input logic payload[$], input int max_gap);
      logic [5:0] syms[$];
      logic       bits[$];
      logic       last;
      expected_symbols(m, payload, syms);
      foreach (syms[k]) begin
         last = (k == syms.size() - 1);
         exp_q.push_back({last, syms[k]});
      end
      build_frame(SYNC_WORD, payload, bits);
      mod_sel = m;
      send_bits(bits, max_gap);
   endtask

   // drain the expected queue and watch a little longer for stray strobes
   task automatic wait_idle();
      int waited;
      waited = 0;
      while (exp_q.size() != 0 && waited < 32) begin
         @(negedge data_clk);
         waited++;
      end
      if (exp_q.size() != 0) begin
         $display("%0d expected symbols never arrived by %0t, synchronizer in %s",
                  exp_q.size(), $time, dut_i.sync_i.state.name());
         other_errors++;
         exp_q.delete();
      end
      repeat (2) begin
         @(negedge data_clk);
      end
   endtask

   initial begin : main
      logic       pay[$];
      logic       bits[$];
      logic       none[$];
      logic [5:0] syms[$];
      int         n0;
      data_clk = 1'b0;
      rst_n    = 1'b0;
      enable   = 1'b0;
      data_in  = 1'b0;
      mod_sel  = MOD_BPSK;
      none     = {};
      repeat (4) begin
         @(negedge data_clk);
      end
      rst_n = 1'b1;

      // near match with one bit off followed by plain noise
      expect_idle = 1'b1;
      build_frame(SYNC_WORD ^ 12'h001, none, bits);
      send_bits(bits, 0);
      clear_window(0);
      noise_bits(SYNC_WORD, 150, bits);
      send_bits(bits, MAX_GAP);
      clear_window(0);
      repeat (4) begin
         @(negedge data_clk);
      end
      expect_idle = 1'b0;
      check_value(sym_seen, 0, "symbols during noise");

      // qpsk frame after noise
      noise_bits(SYNC_WORD, 30, bits);
      send_bits(bits, 0);
      clear_window(0);
      random_payload(PAYLOAD_BITS, pay);
      n0 = sym_seen;
      send_frame(MOD_QPSK, pay, 0);
      wait_idle();
      check_value(sym_seen - n0, PAYLOAD_BITS / 2, "qpsk symbol count");

      // bpsk and 16-qam
      random_payload(PAYLOAD_BITS, pay);
      n0 = sym_seen;
      send_frame(MOD_BPSK, pay, 0);
      wait_idle();
      check_value(sym_seen - n0, PAYLOAD_BITS, "bpsk symbol count");
      random_payload(PAYLOAD_BITS, pay);
      n0 = sym_seen;
      send_frame(MOD_QAM16, pay, 0);
      wait_idle();
      check_value(sym_seen - n0, PAYLOAD_BITS / 4, "16-qam symbol count");

      // same payload without and with enable gaps
      random_payload(PAYLOAD_BITS, pay);
      send_frame(MOD_QAM16, pay, 0);
      wait_idle();
      send_frame(MOD_QAM16, pay, MAX_GAP);
      wait_idle();
      send_frame(MOD_QPSK, pay, MAX_GAP);
      wait_idle();

      // sync word at the end of the payload with the next frame right behind it
      random_payload(PAYLOAD_BITS, pay);
      for (int k = 0; k < 12; k++) begin
         pay[PAYLOAD_BITS - 12 + k] = SYNC_WORD[11 - k];
      end
      send_frame(MOD_QPSK, pay, 0);
      random_payload(PAYLOAD_BITS, pay);
      send_frame(MOD_BPSK, pay, 0);
      wait_idle();

      // half a frame with reset while its last symbol is still in flight
      random_payload(PAYLOAD_BITS / 2, pay);
      expected_symbols(MOD_QPSK, pay, syms);
      for (int k = 0; k < syms.size() - 1; k++) begin
         exp_q.push_back({1'b0, syms[k]});
      end
      build_frame(SYNC_WORD, pay, bits);
      mod_sel = MOD_QPSK;
      send_bits(bits, 0);
      check_value(frame_active, 1'b1, "frame_active in mid frame");
      rst_n = 1'b0;
      repeat (4) begin
         @(negedge data_clk);
         check_value(sym_valid, 1'b0, "sym_valid in reset");
         check_value(frame_active, 1'b0, "frame_active in reset");
      end
      if (exp_q.size() != 0) begin
         $display("%0d symbols before the reset never arrived", exp_q.size());
         other_errors++;
         exp_q.delete();
      end
      rst_n = 1'b1;
      random_payload(PAYLOAD_BITS, pay);
      send_frame(MOD_QAM16, pay, MAX_GAP);
      wait_idle();

      $display("summary: %0d check errors, %0d other errors", check_errors, other_errors);
      if (check_errors + other_errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

// ==== tb.f ====
+incdir+include
design/baseband_pkg.sv
design/header_sync.sv
design/symbol_mapper.sv
design/baseband_rx_top.sv
sim/baseband_rx_tb.sv
